// File: Makefile
VERILATOR ?= verilator
TOP       ?= fpu_tb
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# pass only if the simulation output holds the pass line.
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
hw/fpu_pkg.sv
hw/fpu_control.sv
hw/fpu_operand_unpack.sv
hw/fpu_add_sub.sv
hw/fpu_mul.sv
hw/fpu_result_pack.sv
hw/fpu_top.sv
test/fpu_tb.sv

// File: hw/fpu_add_sub.sv
`timescale 1ns/1ps

module fpu_add_sub
  import fpu_pkg::*;
(
  input  e_fpu_op op,
  input  logic    a_sign,
  input  exp_t    a_exp,
  input  sig_t    a_sig,
  input  logic    a_inf,
  input  logic    a_zero,
  input  logic    b_sign,
  input  exp_t    b_exp,
  input  sig_t    b_sig,
  input  logic    b_inf,
  input  logic    b_zero,
  output fp_t     addsub_result
);

  logic             a_big;
  exp_t             diff;
  exp_t             exp_big;
  logic [ADD_W-1:0] a_al;
  logic [ADD_W-1:0] b_al;
  logic [ADD_W-1:0] a_tc;
  logic [ADD_W-1:0] b_tc;
  logic [ADD_W-1:0] sum;
  logic [ADD_W-1:0] mag;
  logic [ADD_W-1:0] mag1;
  logic [ADD_W-1:0] norm;
  logic [EXP_W:0]   e1;
  logic [EXP_W:0]   e_norm;
  logic [EXP_W:0]   e_field;
  logic [4:0]       lz;
  logic [4:0]       shift;
  logic             b_eff_sign;
  logic             res_sign;
  logic             round_up;
  logic [SIG_W:0]   rounded;
  logic [MAN_W-1:0] frac;

  // shift right, folding every dropped bit into the sticky position.
  function automatic logic [ADD_W-1:0] align(input sig_t s, input exp_t amount);
    logic [ADD_W-1:0] ext;
    logic [ADD_W-1:0] shifted;
    logic             sticky;
    ext     = {2'b00, s, 3'b000};
    shifted = ext >> amount;
    sticky  = (shifted << amount) != ext;
    return {shifted[ADD_W-1:1], shifted[0] | sticky};
  endfunction

  function automatic logic [4:0] lzc(input logic [ADD_W-3:0] v);
    for (int i = ADD_W - 3; i >= 0; i--) begin
      if (v[i]) return 5'(ADD_W - 3 - i);
    end
    return 5'(ADD_W - 2);
  endfunction

  // ------------------------------
  // align and add
  // ------------------------------
  assign a_big      = a_exp >= b_exp;
  assign diff       = a_big ? a_exp - b_exp : b_exp - a_exp;
  assign exp_big    = a_big ? a_exp : b_exp;
  assign a_al       = a_big ? {2'b00, a_sig, 3'b000} : align(a_sig, diff);
  assign b_al       = a_big ? align(b_sig, diff) : {2'b00, b_sig, 3'b000};
  assign b_eff_sign = b_sign ^ (op == op_sub);
  assign a_tc       = a_sign ? -a_al : a_al;
  assign b_tc       = b_eff_sign ? -b_al : b_al;
  assign sum        = a_tc + b_tc;
  assign res_sign   = sum[ADD_W-1];
  assign mag        = res_sign ? -sum : sum;

  // carry out moves the point one place left.
  assign mag1 = mag[ADD_W-2] ? {1'b0, mag[ADD_W-1:2], mag[1] | mag[0]} : mag;
  assign e1   = {1'b0, exp_big} + (EXP_W+1)'(mag[ADD_W-2]);

  // ------------------------------
  // normalize, stopping at exponent 1
  // ------------------------------
  assign lz     = lzc(mag1[ADD_W-3:0]);
  assign shift  = ((EXP_W+1)'(lz) < e1) ? lz : 5'(e1 - (EXP_W+1)'(1));
  assign norm   = mag1 << shift;
  assign e_norm = e1 - (EXP_W+1)'(shift);

  // nearest even on guard, round and sticky.
  assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
  assign rounded  = {1'b0, norm[ADD_W-3:3]} + (SIG_W+1)'(round_up);
  assign e_field  = rounded[SIG_W]   ? e_norm + (EXP_W+1)'(1) :
                    rounded[SIG_W-1] ? e_norm : '0;
  assign frac     = rounded[SIG_W] ? rounded[SIG_W-1:1] : rounded[MAN_W-1:0];

  always_comb begin
    if (a_inf && b_inf) begin
      addsub_result = (a_sign != b_eff_sign) ? QNAN :
                      {a_sign, EXP_W'(EXP_MAX), {MAN_W{1'b0}}};
    end else if (a_inf) begin
      addsub_result = {a_sign, EXP_W'(EXP_MAX), {MAN_W{1'b0}}};
    end else if (b_inf) begin
      addsub_result = {b_eff_sign, EXP_W'(EXP_MAX), {MAN_W{1'b0}}};
    end else if ((a_zero && b_zero) || mag == '0) begin
      addsub_result = '0;
    end else begin
      addsub_result = {res_sign, e_field[EXP_W-1:0], frac};
    end
  end

endmodule

// File: hw/fpu_control.sv
`timescale 1ns/1ps

module fpu_control
  import fpu_pkg::*;
(
  input  logic clk,
  input  logic arst,
  input  logic start,
  output logic load,
  output logic busy,
  output logic cmd_end
);

  e_seq_st state;
  e_seq_st next_state;
  logic    start_r;

  // start is sampled once before the sequence leaves idle.
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      start_r <= 1'b0;
    end else begin
      start_r <= start;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (start_r) next_state = fpu_pkg::load;
      end
      fpu_pkg::load: next_state = execute;
      execute:       next_state = result_valid;
      result_valid:  next_state = finish;
      finish:        next_state = wait_start_low;
      wait_start_low: begin
        if (!start) next_state = idle;
      end
      default:       next_state = idle;
    endcase
  end

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  // ------------------------------
  // registered outputs
  // ------------------------------
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      load    <= 1'b0;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
    end else begin
      load    <= (next_state == fpu_pkg::load);
      busy    <= (next_state != idle);
      // result is reported once the wait state holds.
      cmd_end <= (state == wait_start_low) && (next_state == wait_start_low);
    end
  end

endmodule

// File: hw/fpu_mul.sv
`timescale 1ns/1ps

module fpu_mul
  import fpu_pkg::*;
(
  input  logic a_sign,
  input  exp_t a_exp,
  input  sig_t a_sig,
  input  logic a_inf,
  input  logic a_zero,
  input  logic b_sign,
  input  exp_t b_exp,
  input  sig_t b_sig,
  input  logic b_inf,
  input  logic b_zero,
  output fp_t  mul_result
);

  logic [2*SIG_W-1:0] product;
  logic [2*SIG_W-1:0] prod_norm;
  logic [EXP_W+1:0]   exp_sum;
  logic [EXP_W+1:0]   exp_norm;
  logic [EXP_W+1:0]   exp_final;
  logic               guard;
  logic               sticky;
  logic               round_up;
  logic [SIG_W:0]     rounded;
  logic [MAN_W-1:0]   frac;
  logic               sign;

  assign product = (2*SIG_W)'(a_sig) * (2*SIG_W)'(b_sig);
  assign exp_sum = (EXP_W+2)'(a_exp) + (EXP_W+2)'(b_exp) - (EXP_W+2)'(EXP_BIAS);
  assign sign    = a_sign ^ b_sign;

  // product is 1x.xx or 01.xx; bring the leading one to the top bit.
  assign prod_norm = product[2*SIG_W-1] ? product : product << 1;
  assign exp_norm  = exp_sum + (EXP_W+2)'(product[2*SIG_W-1]);

  // ------------------------------
  // round to nearest even
  // ------------------------------
  assign guard    = prod_norm[SIG_W-1];
  assign sticky   = |prod_norm[SIG_W-2:0];
  assign round_up = guard & (sticky | prod_norm[SIG_W]);
  assign rounded  = {1'b0, prod_norm[2*SIG_W-1:SIG_W]} + (SIG_W+1)'(round_up);

  // a rounding carry leaves 10.000, so one more shift.
  assign exp_final = exp_norm + (EXP_W+2)'(rounded[SIG_W]);
  assign frac      = rounded[SIG_W] ? rounded[SIG_W-1:1] : rounded[MAN_W-1:0];

  always_comb begin
    if ((a_zero && b_inf) || (a_inf && b_zero)) begin
      mul_result = QNAN;
    end else if (a_inf || b_inf) begin
      mul_result = {sign, EXP_W'(EXP_MAX), {MAN_W{1'b0}}};
    end else if (a_zero || b_zero) begin
      mul_result = {sign, {(FP_W-1){1'b0}}};
    end else begin
      mul_result = {sign, exp_final[EXP_W-1:0], frac};
    end
  end

endmodule

// File: hw/fpu_operand_unpack.sv
`timescale 1ns/1ps

module fpu_operand_unpack
  import fpu_pkg::*;
(
  input  logic    clk,
  input  logic    arst,
  input  logic    load,
  input  fp_t     a_operand,
  input  fp_t     b_operand,
  input  e_fpu_op operation,
  output e_fpu_op op,
  output logic    a_sign,
  output logic    b_sign,
  output exp_t    a_exp,
  output exp_t    b_exp,
  output sig_t    a_sig,
  output sig_t    b_sig,
  output logic    a_nan,
  output logic    a_inf,
  output logic    a_zero,
  output logic    b_nan,
  output logic    b_inf,
  output logic    b_zero
);

  exp_t a_in_exp;
  exp_t b_in_exp;
  logic a_exp_nz;
  logic b_exp_nz;

  assign a_exp_nz = |a_operand[FP_W-2:MAN_W];
  assign b_exp_nz = |b_operand[FP_W-2:MAN_W];

  // subnormals load as exponent 1 without the hidden bit.
  assign a_in_exp = a_exp_nz ? a_operand[FP_W-2:MAN_W] : exp_t'(|a_operand[MAN_W-1:0]);
  assign b_in_exp = b_exp_nz ? b_operand[FP_W-2:MAN_W] : exp_t'(|b_operand[MAN_W-1:0]);

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      op     <= op_add;
      a_sign <= 1'b0;
      a_exp  <= '0;
      a_sig  <= '0;
      b_sign <= 1'b0;
      b_exp  <= '0;
      b_sig  <= '0;
    end else if (load) begin
      op     <= operation;
      a_sign <= a_operand[FP_W-1];
      a_exp  <= a_in_exp;
      a_sig  <= {a_exp_nz, a_operand[MAN_W-1:0]};
      b_sign <= b_operand[FP_W-1];
      b_exp  <= b_in_exp;
      b_sig  <= {b_exp_nz, b_operand[MAN_W-1:0]};
    end
  end

  // classes.
  assign a_nan  = (a_exp == EXP_W'(EXP_MAX)) && (|a_sig[MAN_W-1:0]);
  assign a_inf  = (a_exp == EXP_W'(EXP_MAX)) && !(|a_sig[MAN_W-1:0]);
  assign a_zero = (a_exp == '0) && !(|a_sig[MAN_W-1:0]);
  assign b_nan  = (b_exp == EXP_W'(EXP_MAX)) && (|b_sig[MAN_W-1:0]);
  assign b_inf  = (b_exp == EXP_W'(EXP_MAX)) && !(|b_sig[MAN_W-1:0]);
  assign b_zero = (b_exp == '0) && !(|b_sig[MAN_W-1:0]);

endmodule

// File: hw/fpu_pkg.sv
package fpu_pkg;

  // ------------------------------
  // word layout
  // ------------------------------
  localparam int FP_W     = 32;
  localparam int EXP_W    = 8;
  localparam int MAN_W    = 23;
  localparam int SIG_W    = MAN_W + 1;
  localparam int EXP_BIAS = 127;
  localparam int EXP_MAX  = 255;

  // add/sub working width with two integer bits and guard, round and sticky.
  localparam int ADD_W    = SIG_W + 5;

  localparam logic [FP_W-1:0] QNAN = 32'h7fc00000;

  typedef logic [FP_W-1:0]  fp_t;
  typedef logic [EXP_W-1:0] exp_t;
  typedef logic [SIG_W-1:0] sig_t;

  // ------------------------------
  // encodings
  // ------------------------------
  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_mul = 2'd2
  } e_fpu_op;

  typedef enum logic [2:0] {
    idle           = 3'd0,
    load           = 3'd1,
    execute        = 3'd2,
    result_valid   = 3'd3,
    finish         = 3'd4,
    wait_start_low = 3'd5
  } e_seq_st;

endpackage

// File: hw/fpu_result_pack.sv
`timescale 1ns/1ps

module fpu_result_pack
  import fpu_pkg::*;
(
  input  e_fpu_op op,
  input  logic    a_sign,
  input  exp_t    a_exp,
  input  sig_t    a_sig,
  input  logic    b_sign,
  input  exp_t    b_exp,
  input  sig_t    b_sig,
  input  logic    a_nan,
  input  logic    b_nan,
  input  fp_t     addsub_result,
  input  fp_t     mul_result,
  output fp_t     ieee_packet_out
);

  // a NaN operand passes through untouched and a wins over b.
  always_comb begin
    if (a_nan) begin
      ieee_packet_out = {a_sign, a_exp, a_sig[MAN_W-1:0]};
    end else if (b_nan) begin
      ieee_packet_out = {b_sign, b_exp, b_sig[MAN_W-1:0]};
    end else begin
      case (op)
        op_mul:  ieee_packet_out = mul_result;
        default: ieee_packet_out = addsub_result;
      endcase
    end
  end

endmodule

// File: hw/fpu_top.sv
`timescale 1ns/1ps

module fpu_top
  import fpu_pkg::*;
(
  input  logic    clk,
  input  logic    arst,
  input  fp_t     a_operand,
  input  fp_t     b_operand,
  input  e_fpu_op operation,
  input  logic    start,
  output fp_t     ieee_packet_out,
  output logic    cmd_end,
  output logic    busy
);

  logic    load;
  e_fpu_op op;
  logic    a_sign, b_sign;
  exp_t    a_exp, b_exp;
  sig_t    a_sig, b_sig;
  logic    a_nan, a_inf, a_zero;
  logic    b_nan, b_inf, b_zero;
  fp_t     addsub_result;
  fp_t     mul_result;

  fpu_control u_control (
    .clk(clk), .arst(arst), .start(start),
    .load(load), .busy(busy), .cmd_end(cmd_end)
  );

  fpu_operand_unpack u_unpack (
    .clk(clk), .arst(arst), .load(load),
    .a_operand(a_operand), .b_operand(b_operand), .operation(operation),
    .op(op), .a_sign(a_sign), .b_sign(b_sign), .a_exp(a_exp), .b_exp(b_exp),
    .a_sig(a_sig), .b_sig(b_sig), .a_nan(a_nan), .a_inf(a_inf), .a_zero(a_zero),
    .b_nan(b_nan), .b_inf(b_inf), .b_zero(b_zero)
  );

  fpu_add_sub u_add_sub (
    .op(op),
    .a_sign(a_sign), .a_exp(a_exp), .a_sig(a_sig), .a_inf(a_inf), .a_zero(a_zero),
    .b_sign(b_sign), .b_exp(b_exp), .b_sig(b_sig), .b_inf(b_inf), .b_zero(b_zero),
    .addsub_result(addsub_result)
  );

  fpu_mul u_mul (
    .a_sign(a_sign), .a_exp(a_exp), .a_sig(a_sig), .a_inf(a_inf), .a_zero(a_zero),
    .b_sign(b_sign), .b_exp(b_exp), .b_sig(b_sig), .b_inf(b_inf), .b_zero(b_zero),
    .mul_result(mul_result)
  );

  fpu_result_pack u_result_pack (
    .op(op),
    .a_sign(a_sign), .a_exp(a_exp), .a_sig(a_sig),
    .b_sign(b_sign), .b_exp(b_exp), .b_sig(b_sig),
    .a_nan(a_nan), .b_nan(b_nan),
    .addsub_result(addsub_result), .mul_result(mul_result),
    .ieee_packet_out(ieee_packet_out)
  );

endmodule

// File: test/fpu_tb.sv
`timescale 1ns/1ps

module fpu_tb
  import fpu_pkg::*;
();

  localparam int TIMEOUT = 20;

  logic    clk;
  logic    arst;
  fp_t     a_operand;
  fp_t     b_operand;
  e_fpu_op operation;
  logic    start;
  fp_t     ieee_packet_out;
  logic    cmd_end;
  logic    busy;

  int errors;
  int timeouts;

  fpu_top UUT (
    .clk(clk), .arst(arst), .a_operand(a_operand), .b_operand(b_operand),
    .operation(operation), .start(start), .ieee_packet_out(ieee_packet_out),
    .cmd_end(cmd_end), .busy(busy)
  );

  always #5 clk = ~clk;

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    assert (got === expected) else begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    assert (got === expected) else begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  // ------------------------------
  // reference rules
  // ------------------------------
  function automatic fp_t int_to_fp(input int v);
    int unsigned mag;
    int          p;
    if (v == 0) return '0;
    mag = (v < 0) ? -v : v;
    p = 31;
    while (!mag[p]) p--;
    return {v < 0, 8'(EXP_BIAS + p), 23'(mag << (23 - p))};
  endfunction

  function automatic longint unsigned sig_of(input fp_t f);
    return (f[30:23] != 0) ? {40'd0, 1'b1, f[22:0]} : {41'd0, f[22:0]};
  endfunction

  // subnormals sit at exponent 1.
  function automatic int exp_of(input fp_t f);
    return (f[30:23] != 0) ? int'(f[30:23]) : 1;
  endfunction

  // value is m * 2^(emin - 150); round to nearest even.
  function automatic fp_t round_fp(input logic sign, input longint unsigned m, input int emin);
    int              p;
    int              e;
    int              sh;
    longint unsigned mant;
    longint unsigned rem;
    longint unsigned half;
    if (m == 0) return '0;
    p = 63;
    while (!m[p]) p--;
    e = p + emin - 23;
    if (e < 1) e = 1;
    sh = e - emin;
    if (sh > 0) begin
      mant = m >> sh;
      rem  = m & ((64'd1 << sh) - 1);
      half = 64'd1 << (sh - 1);
      if (rem > half || (rem == half && mant[0])) mant++;
    end else begin
      mant = m << -sh;
    end
    if (mant[24]) begin
      mant = mant >> 1;
      e++;
    end
    return {sign, mant[23] ? 8'(e) : 8'd0, mant[22:0]};
  endfunction

  function automatic fp_t add_model(input fp_t a, input fp_t b, input logic sub);
    int     emin;
    longint va;
    longint vb;
    longint s;
    emin = (exp_of(a) < exp_of(b)) ? exp_of(a) : exp_of(b);
    va = sig_of(a) << (exp_of(a) - emin);
    vb = sig_of(b) << (exp_of(b) - emin);
    if (a[31]) va = -va;
    if (b[31] ^ sub) vb = -vb;
    s = va + vb;
    if (s < 0) return round_fp(1'b1, -s, emin);
    return round_fp(1'b0, s, emin);
  endfunction

  function automatic fp_t mul_model(input fp_t a, input fp_t b);
    return round_fp(a[31] ^ b[31], sig_of(a) * sig_of(b), exp_of(a) + exp_of(b) - 150);
  endfunction

  function automatic fp_t rand_normal(input int lo, input int hi);
    return {1'($urandom), 8'($urandom_range(hi, lo)), 23'($urandom)};
  endfunction

  // ------------------------------
  // one operation through the level handshake
  // ------------------------------
  task automatic run_op(input fp_t a, input fp_t b, input e_fpu_op op, output fp_t result);
    int edges;
    int hold;
    int i;
    result = '0;
    @(posedge clk);
    a_operand <= a;
    b_operand <= b;
    operation <= op;
    start     <= 1'b1;
    // edge 0 is the next rising edge.
    edges = -1;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!busy && edges < TIMEOUT);
    if (!busy) begin
      timeouts++;
      $display("Timeout: busy never rose after start");
      @(posedge clk);
      start <= 1'b0;
      return;
    end
    check_word("busy_rise_edge", edges, 32'd1);
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      check_bit("busy", busy, 1'b1);
    end while (!cmd_end && edges < TIMEOUT);
    if (!cmd_end) begin
      timeouts++;
      $display("Timeout: cmd_end never rose after start");
      @(posedge clk);
      start <= 1'b0;
      return;
    end
    check_word("cmd_end_rise_edge", edges, 32'd6);
    result = ieee_packet_out;
    hold = $urandom_range(3, 0);
    for (i = 0; i < hold; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("busy", busy, 1'b1);
      check_bit("cmd_end", cmd_end, 1'b1);
      check_word("ieee_packet_out", ieee_packet_out, result);
    end
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_bit("busy", busy, 1'b0);
    check_bit("cmd_end", cmd_end, 1'b0);
  endtask

  task automatic expect_op(input fp_t a, input fp_t b, input e_fpu_op op, input fp_t expected);
    fp_t got;
    run_op(a, b, op, got);
    check_word("ieee_packet_out", got, expected);
  endtask

  initial begin
    fp_t  a;
    fp_t  b;
    fp_t  x;
    int   ia;
    int   ib;
    logic sub;
    clk       = 1'b0;
    arst      = 1'b1;
    start     = 1'b0;
    a_operand = '0;
    b_operand = '0;
    operation = op_add;
    errors    = 0;
    timeouts  = 0;
    void'($urandom(32'hdaaa_d1ad));
    repeat (5) begin
      @(negedge clk);
      check_bit("busy", busy, 1'b0);
      check_bit("cmd_end", cmd_end, 1'b0);
    end
    @(posedge clk);
    arst <= 1'b0;
    @(negedge clk);
    check_bit("busy", busy, 1'b0);
    check_bit("cmd_end", cmd_end, 1'b0);

    // exact integer sums.
    repeat (20) begin
      ia  = int'($urandom_range(2000)) - 1000;
      ib  = int'($urandom_range(2000)) - 1000;
      sub = 1'($urandom);
      expect_op(int_to_fp(ia), int_to_fp(ib), sub ? op_sub : op_add,
                int_to_fp(sub ? ia - ib : ia + ib));
    end
    repeat (20) begin
      a = rand_normal(80, 170);
      b = rand_normal(80, 170);
      expect_op(a, b, op_mul, mul_model(a, b));
    end
    // alignment drops bits of the smaller operand.
    repeat (30) begin
      a   = rand_normal(100, 150);
      b   = {1'($urandom), 8'(a[30:23] - $urandom_range(30, 0)), 23'($urandom)};
      sub = 1'($urandom);
      if (1'($urandom)) begin
        x = a;
        a = b;
        b = x;
      end
      expect_op(a, b, sub ? op_sub : op_add, add_model(a, b, sub));
    end
    repeat (5) begin
      a = {1'b0, 8'd0, 23'($urandom)};
      b = {1'b1, 8'd0, 23'($urandom)};
      expect_op(a, b, op_add, add_model(a, b, 1'b0));
    end
    repeat (3) begin
      x = rand_normal(1, 254);
      expect_op(x, x, op_sub, 32'h0);
    end

    // ------------------------------
    // special values
    // ------------------------------
    repeat (4) begin
      a = {1'($urandom), 8'hff, 23'($urandom_range(32'h7fffff, 1))};
      b = {1'($urandom), 8'hff, 23'($urandom_range(32'h7fffff, 1))};
      x = rand_normal(1, 254);
      expect_op(a, x, e_fpu_op'($urandom_range(2)), a);
      expect_op(x, b, e_fpu_op'($urandom_range(2)), b);
      expect_op(a, b, e_fpu_op'($urandom_range(2)), a);
    end
    expect_op(32'h7f800000, 32'hff800000, op_add, QNAN);
    expect_op(32'hff800000, 32'hff800000, op_sub, QNAN);
    expect_op(32'h80000000, 32'h7f800000, op_mul, QNAN);
    expect_op(32'hff800000, 32'h00000000, op_mul, QNAN);
    repeat (4) begin
      x   = rand_normal(1, 254);
      b   = {1'($urandom), 8'hff, 23'd0};
      sub = 1'($urandom);
      expect_op(x, b, sub ? op_sub : op_add, {b[31] ^ sub, 8'hff, 23'd0});
      expect_op(b, x, sub ? op_sub : op_add, b);
      a = {1'($urandom), 31'd0};
      expect_op(a, x, op_mul, {a[31] ^ x[31], 31'd0});
      expect_op(x, a, op_mul, {a[31] ^ x[31], 31'd0});
    end

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
